// ==== tb.f ====
rtl/llc_pkg.sv
rtl/llc_write_decoder.sv
rtl/llc_way_bank.sv
rtl/llc_evict_way_mem.sv
rtl/llc_localmem.sv
bench/llc_localmem_sva.sv
bench/tb_llc_localmem.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_llc_localmem
LOG         ?= sim.log
OBJ_DIR     ?= obj_dir
ERROR_LIMIT ?= 100

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --timing --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_llc_localmem.sv ====
//########################################
// llc local memory testbench
//########################################

`timescale 1ns/1ps

module tb_llc_localmem;

    import llc_pkg::*;

    localparam int num_ways = LLC_WAYS;
    localparam int num_sets = 2 ** LLC_SET_BITS;

    typedef logic [num_ways-1:0] way_mask_t;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          rd_en;
    llc_set_t                      set_in;
    logic                          wr_en;
    llc_wr_req_t                   wr_req;
    way_mask_t                     wr_rst_flush;
    logic                          wr_en_evict_way;
    llc_way_t                      wr_data_evict_way;
    llc_way_rd_t [num_ways-1:0]    rd_data;
    llc_way_t                      rd_data_evict_way;

    int reads_issued = 0;

    always #2 clk = ~clk;

    llc_localmem i_dut (
        .clk               (clk),
        .reset             (reset),
        .rd_en             (rd_en),
        .set_in            (set_in),
        .wr_en             (wr_en),
        .wr_req            (wr_req),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data           (rd_data),
        .rd_data_evict_way (rd_data_evict_way)
    );

    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string failed_field();
        if (i_dut.i_sva.fail_line) return "line";
        if (i_dut.i_sva.fail_info) return "info";
        if (i_dut.i_sva.fail_coh) return "coh";
        if (i_dut.i_sva.fail_evict) return "evict way";
        return "";
    endfunction

    // flags are set at the rising edge, so look at them half a cycle later
    always @(negedge clk) begin
        if (failed_field() != "") begin
            stop_failed($sformatf("CHECK FAILED at %0t: %s of the read data is wrong",
                                  $time, failed_field()));
        end
    end

    function automatic llc_coh_t random_coh();
        llc_coh_t coh;
        coh.state   = llc_state_t'($urandom_range(5, 0));
        coh.dirty   = ($urandom_range(1, 0) == 1);
        coh.sharers = sharers_t'($urandom);
        return coh;
    endfunction

    function automatic llc_wr_req_t random_req();
        llc_wr_req_t req;
        req.set  = llc_set_t'($urandom);
        req.way  = llc_way_t'($urandom);
        req.line = {$urandom, $urandom, $urandom, $urandom};
        req.info = llc_info_t'($urandom);
        req.coh  = random_coh();
        return req;
    endfunction

    task automatic drive(input logic rd, input llc_set_t rd_set, input logic wr,
                         input llc_wr_req_t req, input way_mask_t flush,
                         input logic ev_wr, input llc_way_t ev_data);
        @(posedge clk);
        rd_en             <= rd;
        set_in            <= rd_set;
        wr_en             <= wr;
        wr_req            <= req;
        wr_rst_flush      <= flush;
        wr_en_evict_way   <= ev_wr;
        wr_data_evict_way <= ev_data;
        if (rd) begin
            reads_issued++;
        end
    endtask

    // every issued read has to reach the checker before moving on
    task automatic drain_reads();
        int cycles;
        cycles = 0;
        drive(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
        while (i_dut.i_sva.reads_checked != reads_issued && cycles < 16) begin
            @(posedge clk);
            cycles++;
        end
        if (i_dut.i_sva.reads_checked != reads_issued) begin
            stop_failed("timeout: outstanding reads were never checked");
        end
    endtask

    initial begin
        llc_wr_req_t req;
        llc_coh_t    clean;
        way_mask_t   flush;
        llc_set_t    rd_set;
        logic        wr;
        logic        rd;
        logic        ev_wr;
        int          dir_sets [3];

        void'($urandom(32'h8085823e));
        dir_sets          = '{3, 9, 14};
        reset             <= 1'b1;
        rd_en             <= 1'b0;
        set_in            <= '0;
        wr_en             <= 1'b0;
        wr_req            <= '0;
        wr_rst_flush      <= '0;
        wr_en_evict_way   <= 1'b0;
        wr_data_evict_way <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // flush every set, wr_req.way and line carry noise that must not land
        clean = '{state: INVALID, dirty: 1'b0, sharers: '0};
        for (int s = 0; s < num_sets; s++) begin
            req     = random_req();
            req.set = llc_set_t'(s);
            req.coh = clean;
            drive(1'b0, llc_set_t'(s), 1'b0, req, '1, 1'b1, llc_way_t'(s));
        end
        for (int s = 0; s < num_sets; s++) begin
            drive(1'b1, llc_set_t'(s), 1'b0, random_req(), '0, 1'b0, '0);
        end
        drain_reads();

        for (int k = 0; k < 3; k++) begin
            for (int w = 0; w < num_ways; w++) begin
                req     = random_req();
                req.set = llc_set_t'(dir_sets[k]);
                req.way = llc_way_t'(w);
                drive(1'b0, '0, 1'b1, req, '0, 1'b0, '0);
            end
            drive(1'b1, llc_set_t'(dir_sets[k]), 1'b0, random_req(), '0, 1'b0, '0);
        end
        drain_reads();

        // random mix, a quarter of the reads hit the set being written
        for (int i = 0; i < 600; i++) begin
            req    = random_req();
            wr     = ($urandom_range(3, 0) != 0);
            flush  = ($urandom_range(3, 0) == 0) ? way_mask_t'($urandom) : '0;
            rd     = ($urandom_range(1, 0) == 1);
            rd_set = ($urandom_range(3, 0) == 0) ? req.set : llc_set_t'($urandom);
            ev_wr  = ($urandom_range(3, 0) == 0);
            drive(rd, rd_set, wr, req, flush, ev_wr, llc_way_t'($urandom));
        end
        drain_reads();

        @(negedge clk);
        if (failed_field() != "") begin
            stop_failed($sformatf("CHECK FAILED at %0t: %s of the read data is wrong",
                                  $time, failed_field()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== bench/llc_localmem_sva.sv ====
//########################################
// llc local memory checks
//########################################

`timescale 1ns/1ps

module llc_localmem_sva #(
    parameter int num_ways = llc_pkg::LLC_WAYS,
    parameter int num_sets = 2 ** llc_pkg::LLC_SET_BITS
) (
    input logic                                clk,
    input logic                                reset,
    input logic                                rd_en,
    input llc_pkg::llc_set_t                   set_in,
    input logic                                wr_en,
    input llc_pkg::llc_wr_req_t                wr_req,
    input logic [num_ways-1:0]                 wr_rst_flush,
    input logic                                wr_en_evict_way,
    input llc_pkg::llc_way_t                   wr_data_evict_way,
    input llc_pkg::llc_way_rd_t [num_ways-1:0] rd_data,
    input llc_pkg::llc_way_t                   rd_data_evict_way
);

    import llc_pkg::*;

    // shadow storage, an entry is compared only once it holds a known value
    line_t       sh_line     [num_ways][num_sets];
    llc_info_t   sh_info     [num_ways][num_sets];
    llc_coh_t    sh_coh      [num_ways][num_sets];
    llc_way_t    sh_evict    [num_sets];
    bit          info_known  [num_ways][num_sets];
    bit          coh_known   [num_ways][num_sets];
    bit          evict_known [num_sets];

    // expected contents of the read registers
    llc_way_rd_t exp_rd      [num_ways];
    bit          exp_info_ok [num_ways];
    bit          exp_coh_ok  [num_ways];
    llc_way_t    exp_evict;
    bit          exp_evict_ok;
    bit          rd_pending;

    int          reads_checked;
    bit          fail_line;
    bit          fail_info;
    bit          fail_coh;
    bit          fail_evict;

    logic        line_match;
    logic        info_match;
    logic        coh_match;
    logic        evict_match;

    always @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_ways; w++) begin
                exp_rd[w]      <= '0;
                exp_info_ok[w] <= 1'b1;
                exp_coh_ok[w]  <= 1'b1;
            end
            exp_evict    <= '0;
            exp_evict_ok <= 1'b1;
        end else if (rd_en) begin
            // shadow still holds the old contents here
            for (int w = 0; w < num_ways; w++) begin
                exp_rd[w].line <= sh_line[w][set_in];
                exp_rd[w].info <= sh_info[w][set_in];
                exp_rd[w].coh  <= sh_coh[w][set_in];
                exp_info_ok[w] <= info_known[w][set_in];
                exp_coh_ok[w]  <= coh_known[w][set_in];
            end
            exp_evict    <= sh_evict[set_in];
            exp_evict_ok <= evict_known[set_in];
        end
        for (int w = 0; w < num_ways; w++) begin
            if (wr_en && wr_req.way == llc_way_t'(w)) begin
                sh_line[w][wr_req.set]    <= wr_req.line;
                sh_info[w][wr_req.set]    <= wr_req.info;
                info_known[w][wr_req.set] <= 1'b1;
            end
            if (wr_rst_flush[w] || (wr_en && wr_req.way == llc_way_t'(w))) begin
                sh_coh[w][wr_req.set]    <= wr_req.coh;
                coh_known[w][wr_req.set] <= 1'b1;
            end
        end
        if (wr_en_evict_way) begin
            sh_evict[set_in]    <= wr_data_evict_way;
            evict_known[set_in] <= 1'b1;
        end
        rd_pending <= rd_en && !reset;
        if (rd_pending) begin
            reads_checked <= reads_checked + 1;
        end
    end

    always_comb begin
        line_match = 1'b1;
        info_match = 1'b1;
        coh_match  = 1'b1;
        for (int w = 0; w < num_ways; w++) begin
            if (exp_info_ok[w] && rd_data[w].line !== exp_rd[w].line) begin
                line_match = 1'b0;
            end
            if (exp_info_ok[w] && rd_data[w].info !== exp_rd[w].info) begin
                info_match = 1'b0;
            end
            if (exp_coh_ok[w] && rd_data[w].coh !== exp_rd[w].coh) begin
                coh_match = 1'b0;
            end
        end
    end

    assign evict_match = !exp_evict_ok || (rd_data_evict_way === exp_evict);

    a_line: assert property (@(posedge clk) line_match)
        else begin
            $error("rd_data line differs from the shadow copy");
            fail_line = 1'b1;
        end

    a_info: assert property (@(posedge clk) info_match)
        else begin
            $error("rd_data info differs from the shadow copy");
            fail_info = 1'b1;
        end

    a_coh: assert property (@(posedge clk) coh_match)
        else begin
            $error("rd_data coh differs from the shadow copy");
            fail_coh = 1'b1;
        end

    a_evict: assert property (@(posedge clk) evict_match)
        else begin
            $error("rd_data_evict_way differs from the shadow copy");
            fail_evict = 1'b1;
        end

endmodule

bind llc_localmem llc_localmem_sva #(
    .num_ways          (num_ways),
    .num_sets          (num_sets)
) i_sva (
    .clk               (clk),
    .reset             (reset),
    .rd_en             (rd_en),
    .set_in            (set_in),
    .wr_en             (wr_en),
    .wr_req            (wr_req),
    .wr_rst_flush      (wr_rst_flush),
    .wr_en_evict_way   (wr_en_evict_way),
    .wr_data_evict_way (wr_data_evict_way),
    .rd_data           (rd_data),
    .rd_data_evict_way (rd_data_evict_way)
);

// ==== rtl/llc_localmem.sv ====
//########################################
// llc local memory
//########################################

`timescale 1ns/1ps

module llc_localmem #(
    parameter int num_ways = llc_pkg::LLC_WAYS,
    parameter int num_sets = 2 ** llc_pkg::LLC_SET_BITS
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 rd_en,
    input  llc_pkg::llc_set_t                    set_in,
    input  logic                                 wr_en,
    input  llc_pkg::llc_wr_req_t                 wr_req,
    input  logic [num_ways-1:0]                  wr_rst_flush,
    input  logic                                 wr_en_evict_way,
    input  llc_pkg::llc_way_t                    wr_data_evict_way,
    output llc_pkg::llc_way_rd_t [num_ways-1:0]  rd_data,
    output llc_pkg::llc_way_t                    rd_data_evict_way
);

    import llc_pkg::*;

    logic [num_ways-1:0] wr_en_coh;
    logic [num_ways-1:0] wr_en_info;

    // set and way of the write request
    llc_set_t wr_set;
    llc_way_t wr_way;

    assign wr_set = wr_req.set;
    assign wr_way = wr_req.way;

    llc_write_decoder #(
        .num_ways     (num_ways)
    ) i_write_decoder (
        .wr_en        (wr_en),
        .way          (wr_way),
        .wr_rst_flush (wr_rst_flush),
        .wr_en_coh    (wr_en_coh),
        .wr_en_info   (wr_en_info)
    );

    // all ways are read in parallel at set_in
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        llc_way_bank #(
            .num_sets   (num_sets)
        ) i_way_bank (
            .clk        (clk),
            .reset      (reset),
            .rd_en      (rd_en),
            .rd_set     (set_in),
            .wr_set     (wr_set),
            .wr_en_info (wr_en_info[w]),
            .wr_en_coh  (wr_en_coh[w]),
            .wr_line    (wr_req.line),
            .wr_info    (wr_req.info),
            .wr_coh     (wr_req.coh),
            .rd_data    (rd_data[w])
        );
    end

    // pointer writes use the read address, not wr_req.set
    llc_evict_way_mem #(
        .num_sets (num_sets)
    ) i_evict_way_mem (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .set_in   (set_in),
        .wr_en    (wr_en_evict_way),
        .wr_data  (wr_data_evict_way),
        .rd_data  (rd_data_evict_way)
    );

endmodule

// ==== rtl/llc_evict_way_mem.sv ====
//########################################
// llc eviction way pointers
//########################################

`timescale 1ns/1ps

module llc_evict_way_mem #(
    parameter int num_sets = 2 ** llc_pkg::LLC_SET_BITS
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_en,
    input  llc_pkg::llc_set_t set_in,
    input  logic              wr_en,
    input  llc_pkg::llc_way_t wr_data,
    output llc_pkg::llc_way_t rd_data
);

    import llc_pkg::*;

    // next victim of each set, kept by the controller round robin
    llc_way_t evict_mem [num_sets];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            evict_mem[set_in] <= wr_data;
        end
    end

    // same read-first rule as the way banks
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= evict_mem[set_in];
        end
    end

endmodule

// ==== rtl/llc_way_bank.sv ====
//########################################
// llc storage of one way
//########################################

`timescale 1ns/1ps

module llc_way_bank #(
    parameter int num_sets = 2 ** llc_pkg::LLC_SET_BITS
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rd_en,
    input  llc_pkg::llc_set_t    rd_set,
    input  llc_pkg::llc_set_t    wr_set,
    input  logic                 wr_en_info,
    input  logic                 wr_en_coh,
    input  llc_pkg::line_t       wr_line,
    input  llc_pkg::llc_info_t   wr_info,
    input  llc_pkg::llc_coh_t    wr_coh,
    output llc_pkg::llc_way_rd_t rd_data
);

    import llc_pkg::*;

    line_t     line_mem [num_sets];
    llc_info_t info_mem [num_sets];
    llc_coh_t  coh_mem  [num_sets];

    // line and info go together, coh has its own enable for flush
    always_ff @(posedge clk) begin
        if (wr_en_info) begin
            line_mem[wr_set] <= wr_line;
            info_mem[wr_set] <= wr_info;
        end
        if (wr_en_coh) begin
            coh_mem[wr_set] <= wr_coh;
        end
    end

    // registered read, sees the contents from before a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data.line <= line_mem[rd_set];
            rd_data.info <= info_mem[rd_set];
            rd_data.coh  <= coh_mem[rd_set];
        end
    end

endmodule

// ==== rtl/llc_write_decoder.sv ====
//########################################
// llc way write enables
//########################################

`timescale 1ns/1ps

module llc_write_decoder #(
    parameter int num_ways = llc_pkg::LLC_WAYS
) (
    input  logic                  wr_en,
    input  llc_pkg::llc_way_t     way,
    input  logic [num_ways-1:0]   wr_rst_flush,
    output logic [num_ways-1:0]   wr_en_coh,
    output logic [num_ways-1:0]   wr_en_info
);

    import llc_pkg::*;

    // one-hot select of the addressed way
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            wr_en_info[w] = wr_en && (way == llc_way_t'(w));
        end
    end

    // flush touches only the coherence fields, but of any number of ways
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            wr_en_coh[w] = wr_en_info[w] | wr_rst_flush[w];
        end
    end

endmodule

// ==== rtl/llc_pkg.sv ====
//########################################
// llc local memory types
//########################################

package llc_pkg;

    // cache geometry
    localparam int LLC_WAYS = 8;
    localparam int LLC_WAY_BITS = $clog2(LLC_WAYS);
    localparam int LLC_SET_BITS = 4;

    // field widths
    localparam int LLC_TAG_BITS = 20;
    localparam int LLC_LINE_BITS = 128;
    localparam int LLC_SHARERS_BITS = 16;
    localparam int LLC_OWNER_BITS = 4;

    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [LLC_LINE_BITS-1:0] line_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [LLC_SHARERS_BITS-1:0] sharers_t;
    typedef logic [LLC_OWNER_BITS-1:0] owner_t;
    typedef logic hprot_t;

    // directory state of a line, SD is shared with data still pending
    typedef enum logic [2:0] {
        INVALID   = 3'b000,
        VALID     = 3'b001,
        SHARED    = 3'b010,
        EXCLUSIVE = 3'b011,
        MODIFIED  = 3'b100,
        SD        = 3'b101
    } llc_state_t;

    // coherence fields, written by normal writes and by flush
    typedef struct packed {
        llc_state_t state;
        logic       dirty;
        sharers_t   sharers;
    } llc_coh_t;

    // tag and ownership, written by normal writes only
    typedef struct packed {
        llc_tag_t tag;
        owner_t   owner;
        hprot_t   hprot;
    } llc_info_t;

    // contents of one way as seen on the read port
    typedef struct packed {
        line_t     line;
        llc_info_t info;
        llc_coh_t  coh;
    } llc_way_rd_t;

    // write request for the way banks
    typedef struct packed {
        llc_set_t  set;
        llc_way_t  way;
        line_t     line;
        llc_info_t info;
        llc_coh_t  coh;
    } llc_wr_req_t;

endpackage
